//--- logic/trigger_pkg.sv
package trigger_pkg;

    // stream layout, one beat per clock
    localparam int adc_width   = 12;
    localparam int lane_width  = 16;
    localparam int lanes       = 8;
    localparam int tdata_width = lanes * lane_width;

    // time stamp, length counters and event counter
    localparam int stamp_width = 16;
    localparam int len_width   = 8;
    localparam int count_width = 8;

    // apb bus
    localparam int addr_width = 8;
    localparam int data_width = 32;

    // register byte offsets, one 32-bit word each
    localparam logic [addr_width-1:0] reg_ctrl       = 8'h00;
    localparam logic [addr_width-1:0] reg_baseline   = 8'h04;
    localparam logic [addr_width-1:0] reg_threshold  = 8'h08;
    localparam logic [addr_width-1:0] reg_post_len   = 8'h0c;
    localparam logic [addr_width-1:0] reg_acqui_len  = 8'h10;
    localparam logic [addr_width-1:0] reg_evt_stamp  = 8'h14;
    localparam logic [addr_width-1:0] reg_evt_peak   = 8'h18;
    localparam logic [addr_width-1:0] reg_evt_status = 8'h1c;

    // evt_status layout: bit 0 over-length, count above it
    localparam int status_count_lsb = 8;

    // about 10 percent of full scale
    localparam logic [adc_width-1:0] threshold_rst = 409;
    localparam logic [len_width-1:0] post_len_rst  = 38;
    localparam logic [len_width-1:0] acqui_len_rst = 100;

    typedef enum logic [1:0] {
        run_idle      = 2'b00,
        run_calibrate = 2'b01,
        run_armed     = 2'b11
    } run_state_t;

    // sample in the upper bits of its lane, minus baseline, one guard bit
    function automatic logic signed [adc_width:0] lane_diff(
        input logic [tdata_width-1:0]        tdata,
        input int                            lane,
        input logic signed [adc_width-1:0]   baseline
    );
        logic signed [adc_width-1:0] sample;
        sample = tdata[lane * lane_width + lane_width - 1 -: adc_width];
        return {sample[adc_width-1], sample} - {baseline[adc_width-1], baseline};
    endfunction

endpackage

//--- logic/apb_trigger_regs.sv
module apb_trigger_regs (
    input  logic                                      AXIS_ACLK,
    input  logic                                      AXIS_ARESETN,
    input  logic                                      psel,
    input  logic                                      penable,
    input  logic                                      pwrite,
    input  logic [trigger_pkg::addr_width-1:0]        paddr,
    input  logic [trigger_pkg::data_width-1:0]        pwdata,
    output logic [trigger_pkg::data_width-1:0]        prdata,
    output logic                                      pready,
    output logic                                      pslverr,
    output trigger_pkg::run_state_t                   run_state,
    output logic signed [trigger_pkg::adc_width-1:0]  baseline,
    output logic [trigger_pkg::adc_width-1:0]         threshold,
    output logic [trigger_pkg::len_width-1:0]         post_len,
    output logic [trigger_pkg::len_width-1:0]         acqui_len,
    input  logic                                      event_valid,
    input  logic [trigger_pkg::stamp_width-1:0]       event_stamp,
    input  logic signed [trigger_pkg::adc_width:0]    event_peak,
    input  logic                                      event_over_len
);

    logic                                     mapped;
    logic                                     wr_en;
    logic [trigger_pkg::count_width-1:0]      evt_count;
    logic [trigger_pkg::stamp_width-1:0]      evt_stamp_q;
    logic signed [trigger_pkg::adc_width:0]   evt_peak_q;
    logic                                     evt_over_len_q;

    always_comb
    begin
        case (paddr)
            trigger_pkg::reg_ctrl,
            trigger_pkg::reg_baseline,
            trigger_pkg::reg_threshold,
            trigger_pkg::reg_post_len,
            trigger_pkg::reg_acqui_len,
            trigger_pkg::reg_evt_stamp,
            trigger_pkg::reg_evt_peak,
            trigger_pkg::reg_evt_status: mapped = 1'b1;
            default:                     mapped = 1'b0;
        endcase
    end

    // zero wait states
    assign pready  = psel;
    assign pslverr = psel && !mapped;
    assign wr_en   = psel && penable && pwrite && mapped;

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            run_state <= trigger_pkg::run_idle;
            baseline  <= '0;
            threshold <= trigger_pkg::threshold_rst;
            post_len  <= trigger_pkg::post_len_rst;
            acqui_len <= trigger_pkg::acqui_len_rst;
            evt_count <= '0;
        end
        else
        begin
            // event registers are read only, writes to them are dropped
            if (wr_en)
            begin
                case (paddr)
                    trigger_pkg::reg_ctrl:
                        run_state <= trigger_pkg::run_state_t'(pwdata[1:0]);
                    trigger_pkg::reg_baseline:
                        baseline <= pwdata[trigger_pkg::adc_width-1:0];
                    trigger_pkg::reg_threshold:
                        threshold <= pwdata[trigger_pkg::adc_width-1:0];
                    trigger_pkg::reg_post_len:
                        post_len <= pwdata[trigger_pkg::len_width-1:0];
                    trigger_pkg::reg_acqui_len:
                        acqui_len <= pwdata[trigger_pkg::len_width-1:0];
                    default:
                        ;
                endcase
            end
            if (event_valid)
            begin
                evt_count <= evt_count + 1;
            end
        end
    end

    // last event record for software polling
    always_ff @(posedge AXIS_ACLK)
    begin
        if (event_valid)
        begin
            evt_stamp_q    <= event_stamp;
            evt_peak_q     <= event_peak;
            evt_over_len_q <= event_over_len;
        end
    end

    always_comb
    begin
        prdata = '0;
        case (paddr)
            trigger_pkg::reg_ctrl:
                prdata[1:0] = run_state;
            trigger_pkg::reg_baseline:
                prdata = {{(trigger_pkg::data_width - trigger_pkg::adc_width)
                          {baseline[trigger_pkg::adc_width-1]}}, baseline};
            trigger_pkg::reg_threshold:
                prdata[trigger_pkg::adc_width-1:0] = threshold;
            trigger_pkg::reg_post_len:
                prdata[trigger_pkg::len_width-1:0] = post_len;
            trigger_pkg::reg_acqui_len:
                prdata[trigger_pkg::len_width-1:0] = acqui_len;
            trigger_pkg::reg_evt_stamp:
                prdata[trigger_pkg::stamp_width-1:0] = evt_stamp_q;
            trigger_pkg::reg_evt_peak:
                prdata = {{(trigger_pkg::data_width - trigger_pkg::adc_width - 1)
                          {evt_peak_q[trigger_pkg::adc_width]}}, evt_peak_q};
            trigger_pkg::reg_evt_status:
            begin
                prdata[0] = evt_over_len_q;
                prdata[trigger_pkg::status_count_lsb +: trigger_pkg::count_width] = evt_count;
            end
            default:
                prdata = '0;
        endcase
    end

endmodule

//--- logic/level_discriminator.sv
module level_discriminator (
    input  logic                                      AXIS_ACLK,
    input  logic                                      AXIS_ARESETN,
    input  logic [trigger_pkg::tdata_width-1:0]       s_axis_tdata,
    input  logic signed [trigger_pkg::adc_width-1:0]  baseline,
    input  logic [trigger_pkg::adc_width-1:0]         threshold,
    output logic [trigger_pkg::lanes-1:0]             hit_mask
);

    // threshold is unsigned, widen with a zero sign bit
    logic signed [trigger_pkg::adc_width:0] threshold_ext;
    logic [trigger_pkg::lanes-1:0]          hit_comb;

    assign threshold_ext = {1'b0, threshold};

    // one comparator per lane
    always_comb
    begin
        for (int i = 0; i < trigger_pkg::lanes; i++)
        begin
            hit_comb[i] = trigger_pkg::lane_diff(s_axis_tdata, i, baseline) >= threshold_ext;
        end
    end

    // one beat of latency
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            hit_mask <= '0;
        end
        else
        begin
            hit_mask <= hit_comb;
        end
    end

endmodule

//--- logic/beat_peak_tracker.sv
module beat_peak_tracker (
    input  logic                                      AXIS_ACLK,
    input  logic                                      AXIS_ARESETN,
    input  logic [trigger_pkg::tdata_width-1:0]       s_axis_tdata,
    input  logic signed [trigger_pkg::adc_width-1:0]  baseline,
    output logic signed [trigger_pkg::adc_width:0]    beat_peak
);

    // binary comparator tree, leaves at lanes..2*lanes-1, root at node 1
    // lanes must be a power of two
    function automatic logic signed [trigger_pkg::adc_width:0] tree_max(
        input logic [trigger_pkg::tdata_width-1:0]      tdata,
        input logic signed [trigger_pkg::adc_width-1:0] base
    );
        logic signed [trigger_pkg::adc_width:0] node [1:2*trigger_pkg::lanes-1];
        for (int i = 0; i < trigger_pkg::lanes; i++)
        begin
            node[trigger_pkg::lanes + i] = trigger_pkg::lane_diff(tdata, i, base);
        end
        for (int n = trigger_pkg::lanes - 1; n >= 1; n--)
        begin
            if (node[2*n] > node[2*n+1])
            begin
                node[n] = node[2*n];
            end
            else
            begin
                node[n] = node[2*n+1];
            end
        end
        return node[1];
    endfunction

    // same latency as the discriminator so peak and hit line up
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            beat_peak <= '0;
        end
        else
        begin
            beat_peak <= tree_max(s_axis_tdata, baseline);
        end
    end

endmodule

//--- logic/acquisition_controller.sv
module acquisition_controller (
    input  logic                                      AXIS_ACLK,
    input  logic                                      AXIS_ARESETN,
    input  trigger_pkg::run_state_t                   run_state,
    input  logic [trigger_pkg::lanes-1:0]             hit_mask,
    input  logic signed [trigger_pkg::adc_width:0]    beat_peak,
    input  logic [trigger_pkg::stamp_width-1:0]       time_now,
    input  logic [trigger_pkg::len_width-1:0]         post_len,
    input  logic [trigger_pkg::len_width-1:0]         acqui_len,
    output logic                                      trig_flag,
    output logic                                      event_valid,
    output logic [trigger_pkg::stamp_width-1:0]       event_stamp,
    output logic signed [trigger_pkg::adc_width:0]    event_peak,
    output logic                                      event_over_len
);

    typedef enum logic {
        st_wait,
        st_open
    } ctrl_state_t;

    ctrl_state_t                            state;
    logic                                   any_hit;
    logic                                   open_now;
    logic [trigger_pkg::len_width-1:0]      quiet_cnt;
    logic [trigger_pkg::len_width-1:0]      total_cnt;
    logic [trigger_pkg::len_width:0]        quiet_next;
    logic [trigger_pkg::len_width:0]        total_next;
    logic                                   quiet_done;
    logic                                   length_done;
    logic signed [trigger_pkg::adc_width:0] peak_next;

    assign any_hit  = |hit_mask;
    assign open_now = (state == st_wait) && any_hit && (run_state == trigger_pkg::run_armed);

    // counters widened by one bit so a zero length still closes
    assign quiet_next  = {1'b0, quiet_cnt} + 1;
    assign total_next  = {1'b0, total_cnt} + 1;
    assign quiet_done  = !any_hit && (quiet_next >= {1'b0, post_len});
    assign length_done = total_next >= {1'b0, acqui_len};

    assign peak_next = (beat_peak > event_peak) ? beat_peak : event_peak;

    assign trig_flag = (state == st_open);

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            state          <= st_wait;
            quiet_cnt      <= '0;
            total_cnt      <= '0;
            event_valid    <= 1'b0;
            event_over_len <= 1'b0;
        end
        else
        begin
            event_valid <= 1'b0;
            case (state)
                st_wait:
                begin
                    // opening beat counts as the first of the event
                    if (open_now)
                    begin
                        state          <= st_open;
                        quiet_cnt      <= '0;
                        total_cnt      <= 1;
                        event_over_len <= 1'b0;
                    end
                end
                st_open:
                begin
                    // run state is ignored here, an open event always runs out
                    if (quiet_done || length_done)
                    begin
                        state          <= st_wait;
                        event_valid    <= 1'b1;
                        event_over_len <= length_done;
                    end
                    else
                    begin
                        total_cnt <= total_next[trigger_pkg::len_width-1:0];
                        if (any_hit)
                        begin
                            quiet_cnt <= '0;
                        end
                        else
                        begin
                            quiet_cnt <= quiet_next[trigger_pkg::len_width-1:0];
                        end
                    end
                end
                default:
                    state <= st_wait;
            endcase
        end
    end

    // stamp at opening, peak runs through the closing beat and then holds
    always_ff @(posedge AXIS_ACLK)
    begin
        if (open_now)
        begin
            event_stamp <= time_now;
            event_peak  <= beat_peak;
        end
        else if (state == st_open)
        begin
            event_peak <= peak_next;
        end
    end

endmodule

//--- logic/adc_trigger_top.sv
module adc_trigger_top (
    input  logic                                      AXIS_ACLK,
    input  logic                                      AXIS_ARESETN,
    input  logic [trigger_pkg::tdata_width-1:0]       s_axis_tdata,
    input  logic [trigger_pkg::stamp_width-1:0]       time_now,
    input  logic                                      psel,
    input  logic                                      penable,
    input  logic                                      pwrite,
    input  logic [trigger_pkg::addr_width-1:0]        paddr,
    input  logic [trigger_pkg::data_width-1:0]        pwdata,
    output logic [trigger_pkg::data_width-1:0]        prdata,
    output logic                                      pready,
    output logic                                      pslverr,
    output logic                                      trig_flag,
    output logic                                      event_valid,
    output logic [trigger_pkg::stamp_width-1:0]       event_stamp,
    output logic signed [trigger_pkg::adc_width:0]    event_peak,
    output logic                                      event_over_len
);

    trigger_pkg::run_state_t                   run_state;
    logic signed [trigger_pkg::adc_width-1:0]  baseline;
    logic [trigger_pkg::adc_width-1:0]         threshold;
    logic [trigger_pkg::len_width-1:0]         post_len;
    logic [trigger_pkg::len_width-1:0]         acqui_len;
    logic [trigger_pkg::lanes-1:0]             hit_mask;
    logic signed [trigger_pkg::adc_width:0]    beat_peak;

    apb_trigger_regs i_apb_trigger_regs (
        .AXIS_ACLK      (AXIS_ACLK),
        .AXIS_ARESETN   (AXIS_ARESETN),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .run_state      (run_state),
        .baseline       (baseline),
        .threshold      (threshold),
        .post_len       (post_len),
        .acqui_len      (acqui_len),
        .event_valid    (event_valid),
        .event_stamp    (event_stamp),
        .event_peak     (event_peak),
        .event_over_len (event_over_len)
    );

    // both stream blocks see the same beat
    level_discriminator i_level_discriminator (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .s_axis_tdata (s_axis_tdata),
        .baseline     (baseline),
        .threshold    (threshold),
        .hit_mask     (hit_mask)
    );

    beat_peak_tracker i_beat_peak_tracker (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .s_axis_tdata (s_axis_tdata),
        .baseline     (baseline),
        .beat_peak    (beat_peak)
    );

    acquisition_controller i_acquisition_controller (
        .AXIS_ACLK      (AXIS_ACLK),
        .AXIS_ARESETN   (AXIS_ARESETN),
        .run_state      (run_state),
        .hit_mask       (hit_mask),
        .beat_peak      (beat_peak),
        .time_now       (time_now),
        .post_len       (post_len),
        .acqui_len      (acqui_len),
        .trig_flag      (trig_flag),
        .event_valid    (event_valid),
        .event_stamp    (event_stamp),
        .event_peak     (event_peak),
        .event_over_len (event_over_len)
    );

endmodule

//--- bench/tb_clock_gen.sv
module tb_clock_gen (
    output logic AXIS_ACLK,
    output logic AXIS_ARESETN
);

    initial
    begin
        AXIS_ACLK = 1'b0;
        forever #20 AXIS_ACLK = ~AXIS_ACLK;
    end

    // released on a rising edge, so the DUT sees reset for the full 5 cycles
    initial
    begin
        AXIS_ARESETN = 1'b0;
        repeat (5) @(posedge AXIS_ACLK);
        AXIS_ARESETN <= 1'b1;
    end

endmodule

//--- bench/tb_adc_trigger.sv
module tb_adc_trigger;

    logic               AXIS_ACLK;
    logic               AXIS_ARESETN;
    logic [127:0]       s_axis_tdata;
    logic [15:0]        time_now;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [7:0]         paddr;
    logic [31:0]        pwdata;
    logic [31:0]        prdata;
    logic               pready;
    logic               pslverr;
    logic               trig_flag;
    logic               event_valid;
    logic [15:0]        event_stamp;
    logic signed [12:0] event_peak;
    logic               event_over_len;

    int fd, code, errors, test_num, test_base, cur_beat, sync_beat;
    int baseline_m, thresh_m, post_m, acqui_m, run_m;
    int m_open, m_quiet, m_total, m_stamp, m_peak, m_over;
    int new_valid, new_trig, new_stamp, new_peak, new_over;
    int old_valid, old_trig, old_stamp, old_peak, old_over;
    int model_events, dut_events, last_stamp, last_peak, last_over;
    int q_stamp[$];
    int q_peak[$];
    int q_over[$];

    tb_clock_gen i_tb_clock_gen (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN)
    );

    adc_trigger_top i_adc_trigger_top (
        .AXIS_ACLK      (AXIS_ACLK),
        .AXIS_ARESETN   (AXIS_ARESETN),
        .s_axis_tdata   (s_axis_tdata),
        .time_now       (time_now),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .trig_flag      (trig_flag),
        .event_valid    (event_valid),
        .event_stamp    (event_stamp),
        .event_peak     (event_peak),
        .event_over_len (event_over_len)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $finish;
    endtask

    task automatic compare(input string name, input int exp, input int got);
        if (exp != got)
        begin
            errors++;
            $display("ERR t=%0t %s exp %0d got %0d", $time, name, exp, got);
        end
    endtask

    // one clock: check outputs of two beats ago, drive a beat, step the model
    task automatic step_beat(input int base, input int lane, input int amp);
        logic [127:0] beat;
        int s, diff, peak, hit, nv;
        @(negedge AXIS_ACLK);
        compare("event_valid", old_valid, event_valid);
        compare("trig_flag", old_trig, trig_flag);
        if (event_valid)
        begin
            dut_events++;
        end
        if (old_valid && event_valid)
        begin
            compare("event_stamp", old_stamp, event_stamp);
            compare("event_peak", old_peak, event_peak);
            compare("event_over_len", old_over, event_over_len);
        end
        hit = 0;
        peak = -100000;
        for (int l = 0; l < 8; l++)
        begin
            s = (l == lane) ? amp : base;
            beat[l*16 +: 16] = {s[11:0], 4'b0000};
            diff = s - baseline_m;
            if (diff >= thresh_m)
            begin
                hit = 1;
            end
            if (diff > peak)
            begin
                peak = diff;
            end
        end
        s_axis_tdata = beat;
        time_now = cur_beat[15:0];
        // event rules applied one beat after the hit is registered
        nv = 0;
        if (!m_open)
        begin
            if (hit && run_m == int'(trigger_pkg::run_armed))
            begin
                m_open = 1;
                m_quiet = 0;
                m_total = 1;
                m_stamp = (cur_beat + 1) % 65536;
                m_peak = peak;
            end
        end
        else
        begin
            if (peak > m_peak)
            begin
                m_peak = peak;
            end
            if ((!hit && m_quiet + 1 >= post_m) || m_total + 1 >= acqui_m)
            begin
                nv = 1;
                m_over = (m_total + 1 >= acqui_m);
                m_open = 0;
                q_stamp.push_back(m_stamp);
                q_peak.push_back(m_peak);
                q_over.push_back(m_over);
                model_events++;
                last_stamp = m_stamp;
                last_peak = m_peak;
                last_over = m_over;
            end
            else
            begin
                m_total++;
                m_quiet = hit ? 0 : m_quiet + 1;
            end
        end
        old_valid = new_valid;
        old_trig = new_trig;
        old_stamp = new_stamp;
        old_peak = new_peak;
        old_over = new_over;
        new_valid = nv;
        new_trig = m_open;
        new_stamp = m_stamp;
        new_peak = m_peak;
        new_over = m_over;
        cur_beat++;
    endtask

    task automatic apb_access(input int wr, input int addr, input int data,
                              output int rdata, output int err);
        int waited;
        step_beat(0, 0, 0);
        psel = 1'b1;
        pwrite = wr[0];
        paddr = addr[7:0];
        pwdata = data;
        penable = 1'b0;
        step_beat(0, 0, 0);
        penable = 1'b1;
        step_beat(0, 0, 0);
        waited = 0;
        while (!pready)
        begin
            if (waited > 20)
            begin
                abort_run("timeout waiting for pready");
            end
            step_beat(0, 0, 0);
            waited++;
        end
        rdata = prdata;
        err = pslverr;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        if (wr && !err)
        begin
            if (addr == trigger_pkg::reg_ctrl)      run_m = data & 3;
            if (addr == trigger_pkg::reg_baseline)  baseline_m = data;
            if (addr == trigger_pkg::reg_threshold) thresh_m = data;
            if (addr == trigger_pkg::reg_post_len)  post_m = data;
            if (addr == trigger_pkg::reg_acqui_len) acqui_m = data;
        end
    endtask

    // quiet beats until model and DUT have nothing in flight
    task automatic drain_events();
        int waited;
        repeat (3) step_beat(0, 0, 0);
        waited = 0;
        while (m_open || old_valid || new_valid || dut_events != model_events)
        begin
            if (waited > 300)
            begin
                abort_run("timeout waiting for the event to close");
            end
            step_beat(0, 0, 0);
            waited++;
        end
    endtask

    initial
    begin
        reg [127:0] tok;
        reg [1023:0] rest;
        int a, v, n, rd, err, waited, e_stamp, e_peak, e_over;
        s_axis_tdata = '0;
        time_now = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        errors = 0;
        test_num = 0;
        test_base = 0;
        cur_beat = 0;
        sync_beat = 0;
        baseline_m = 0;
        thresh_m = 409;
        post_m = 38;
        acqui_m = 100;
        run_m = 0;
        {m_open, m_quiet, m_total, m_stamp, m_peak, m_over} = '0;
        {new_valid, new_trig, new_stamp, new_peak, new_over} = '0;
        {old_valid, old_trig, old_stamp, old_peak, old_over} = '0;
        {model_events, dut_events, last_stamp, last_peak, last_over} = '0;
        fd = $fopen("bench/adc_trigger_trace.txt", "r");
        if (fd == 0)
        begin
            abort_run("cannot open bench/adc_trigger_trace.txt");
        end
        waited = 0;
        while (AXIS_ARESETN !== 1'b1)
        begin
            if (waited > 50)
            begin
                abort_run("timeout waiting for reset release");
            end
            @(negedge AXIS_ACLK);
            waited++;
        end
        code = $fscanf(fd, "%s", tok);
        while (code == 1)
        begin
            if (tok == "#")
            begin
                code = $fgets(rest, fd);
            end
            else if (tok == "T")
            begin
                code = $fscanf(fd, "%d", n);
                if (test_num > 0)
                begin
                    $display("test %0d done, %0d errors", test_num, errors - test_base);
                end
                test_num = n;
                test_base = errors;
            end
            else if (tok == "C")
            begin
                code = $fscanf(fd, "%h %d", a, v);
                apb_access(1, a, v, rd, err);
            end
            else if (tok == "R")
            begin
                code = $fscanf(fd, "%h %d", a, v);
                apb_access(0, a, 0, rd, err);
                compare("prdata", v, rd);
            end
            else if (tok == "U")
            begin
                code = $fscanf(fd, "%h", a);
                apb_access(0, a, 0, rd, err);
                if (!err)
                begin
                    errors++;
                    $display("unmapped address %0h was answered without pslverr", a);
                end
            end
            else if (tok == "S")
            begin
                sync_beat = cur_beat;
            end
            else if (tok == "B")
            begin
                code = $fscanf(fd, "%d %d %d %d", a, v, e_peak, n);
                repeat (n) step_beat(a, v, e_peak);
            end
            else if (tok == "N")
            begin
                drain_events();
                if (q_stamp.size() != 0)
                begin
                    errors++;
                    $display("an event was produced where the trace expects none");
                    q_stamp.delete();
                    q_peak.delete();
                    q_over.delete();
                end
            end
            else if (tok == "E")
            begin
                code = $fscanf(fd, "%d %d %d", e_stamp, e_peak, e_over);
                drain_events();
                if (q_stamp.size() == 0)
                begin
                    errors++;
                    $display("the trace expects an event but none was produced");
                end
                else
                begin
                    compare("trace stamp", sync_beat + e_stamp, q_stamp.pop_front());
                    compare("trace peak", e_peak, q_peak.pop_front());
                    compare("trace over_len", e_over, q_over.pop_front());
                end
                apb_access(0, trigger_pkg::reg_evt_stamp, 0, rd, err);
                compare("reg_evt_stamp", last_stamp, rd);
                apb_access(0, trigger_pkg::reg_evt_peak, 0, rd, err);
                compare("reg_evt_peak", last_peak, $signed(rd));
                apb_access(0, trigger_pkg::reg_evt_status, 0, rd, err);
                compare("reg_evt_status", ((model_events % 256) << 8) | last_over, rd);
            end
            else
            begin
                errors++;
                $display("unknown trace line kind %0s", tok);
            end
            code = $fscanf(fd, "%s", tok);
        end
        $fclose(fd);
        if (test_num > 0)
        begin
            $display("test %0d done, %0d errors", test_num, errors - test_base);
        end
        $display("tests %0d, events %0d, errors %0d", test_num, dut_events, errors);
        if (errors == 0)
        begin
            $display("Simulation PASSED");
        end
        else
        begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- bench/adc_trigger_trace.txt
# T test | C addr value | R addr expected | U unmapped addr | S mark beat
# B base lane amp repeat | N no event | E stamp-after-mark peak over_len
T 1
R 08 409
R 0c 38
R 10 100
B 0 0 0 6
N
T 2
C 04 100
C 08 200
C 0c 4
C 10 20
C 00 3
S
B 0 0 0 3
B 0 2 900 1
B 0 0 0 10
E 4 800 0
T 3
S
B 0 1 500 1
B 0 0 0 2
B 0 5 1200 1
B 0 0 0 2
B 0 3 700 1
B 0 0 0 8
E 1 1100 0
T 4
S
B 0 4 600 30
B 0 0 0 8
E 1 500 1
E 21 500 0
T 5
S
B 0 6 299 1
B 0 0 0 8
N
S
B 0 6 300 1
B 0 0 0 8
E 1 200 0
C 00 0
B 0 6 900 1
B 0 0 0 6
N
C 00 1
B 0 6 900 1
B 0 0 0 6
N
T 6
U 40
U 24

//--- tb.f
logic/trigger_pkg.sv
logic/apb_trigger_regs.sv
logic/level_discriminator.sv
logic/beat_peak_tracker.sv
logic/acquisition_controller.sv
logic/adc_trigger_top.sv
bench/tb_clock_gen.sv
bench/tb_adc_trigger.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_adc_trigger
FILELIST = tb.f

SRCS = $(shell cat $(FILELIST))
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
